/* compile.f */
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/inst_mem.sv
hdl/predecode.sv
hdl/if1_fifo.sv
hdl/fetch_top.sv
bench/fetch_props.sv
bench/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module fetch_tb -f compile.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -Fxq '** PASS **' "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* bench/fetch_tb.sv */
module fetch_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          mem_words = 64;
    localparam logic [31:0] mem_bytes = 32'd4 * mem_words;

    // back-end model phases
    localparam int be_idle      = 0;
    localparam int be_await     = 1;
    localparam int be_wait_ex   = 2;
    localparam int be_wait_done = 3;
    localparam int be_released  = 4;

    logic          clk;
    logic          rst;
    logic          flush;
    logic [31:0]   flush_pc;
    logic          load_en;
    logic [31:0]   load_addr;
    logic [31:0]   load_data;
    logic          out_allowin;
    logic          out_valid;
    fetch_bundle_t out_bundle;
    logic          hold;
    logic          ibar_ex;
    logic          csr_ex;
    logic          tlb_ex;
    logic          cache_idle;
    logic          csr_done;
    logic          tlb_done;

    logic [31:0] prog [mem_words];
    integer      seed;
    int          errors;
    int          timeouts;
    int          bundles;
    int          priv_count;
    string       test_name;
    logic [31:0] model_pc;
    logic        fault_seen;
    int          be_phase;
    int          be_cnt;
    priv_kind_t  be_kind;
    logic [31:0] fpc;

    fetch_top #(
        .mem_depth (mem_words)
    ) fetch_top_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .out_allowin (out_allowin),
        .out_valid   (out_valid),
        .out_bundle  (out_bundle),
        .hold        (hold),
        .ibar_ex     (ibar_ex),
        .csr_ex      (csr_ex),
        .tlb_ex      (tlb_ex),
        .cache_idle  (cache_idle),
        .csr_done    (csr_done),
        .tlb_done    (tlb_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic priv_kind_t opclass(input logic [31:0] w);
        if (w[31:24] == op_ibar) begin
            return kind_ibar;
        end else if (w[31:24] == op_csr) begin
            return kind_csr;
        end else if (w[31:24] == op_tlb) begin
            return kind_tlb;
        end
        return kind_none;
    endfunction

    // expected bundle for a fetch at p, and the class the serializer waits on
    task automatic predict(input logic [31:0] p, output fetch_bundle_t b,
                           output priv_kind_t k);
        logic [5:0]  widx;
        logic [31:0] w0;
        logic [31:0] w1;
        priv_kind_t  c0;
        priv_kind_t  c1;
        b = '0;
        k = kind_none;
        b.pc = p;
        b.pc_next = {p[31:3], 3'b000} + 32'd8;
        if (p >= mem_bytes) begin
            b.inst0     = inst_nop;
            b.inst1     = inst_nop;
            b.badv      = p;
            b.exception = excp_adef;
            b.excp_flag = 2'b01;
        end else begin
            widx = {p[7:3], 1'b0};
            w0 = prog[widx];
            w1 = prog[widx | 6'd1];
            c0 = opclass(w0);
            c1 = opclass(w1);
            // slot 0 is not delivered for an odd-word pc
            b.priv[0] = (c0 != kind_none) && !p[2];
            b.priv[1] = (c1 != kind_none) && !b.priv[0];
            b.inst0 = p[2] ? inst_nop : w0;
            b.inst1 = b.priv[0] ? inst_nop : w1;
            if (b.priv[0]) begin
                k = c0;
            end else if (b.priv[1]) begin
                k = c1;
            end
        end
    endtask

    task automatic check_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", test_name, field, exp_v, act_v);
        end
    endtask

    task automatic compare_bundle(input fetch_bundle_t exp);
        check_field("pc", exp.pc, out_bundle.pc);
        check_field("pc_next", exp.pc_next, out_bundle.pc_next);
        check_field("inst0", exp.inst0, out_bundle.inst0);
        check_field("inst1", exp.inst1, out_bundle.inst1);
        check_field("badv", exp.badv, out_bundle.badv);
        check_field("exception", {25'd0, exp.exception}, {25'd0, out_bundle.exception});
        check_field("excp_flag", {30'd0, exp.excp_flag}, {30'd0, out_bundle.excp_flag});
        check_field("priv", {30'd0, exp.priv}, {30'd0, out_bundle.priv});
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("** Error %s: %s", test_name, what);
    endtask

    // one clock of stimulus, back-end answers and bundle checks
    task automatic step(input logic do_flush, input logic [31:0] target);
        fetch_bundle_t exp;
        priv_kind_t    k;
        logic          take;
        @(posedge clk);
        #2;
        ibar_ex = 1'b0;
        csr_ex = 1'b0;
        tlb_ex = 1'b0;
        csr_done = 1'b0;
        tlb_done = 1'b0;
        cache_idle = (rand_below(2) == 1);
        take = (rand_below(10) >= 3);
        if (do_flush) begin
            flush = 1'b1;
            flush_pc = target;
            out_allowin = 1'b0;
            model_pc = target;
            be_phase = be_idle;
        end else begin
            flush = 1'b0;
            out_allowin = take;
            if (be_phase != be_idle) begin
                assert (!out_valid) else report_problem("bundle offered during a serializer wait");
            end
            if (be_phase == be_idle) begin
                assert (!hold) else report_problem("hold high with no serializing bundle");
            end else if (be_phase == be_released) begin
                assert (!hold) else report_problem("hold still high after the release");
                be_phase = be_idle;
            end else begin
                assert (hold) else report_problem("hold low before the release");
            end
            if (be_phase == be_await) begin
                be_phase = be_wait_ex;
                be_cnt = 1 + rand_below(6);
            end
            if (be_phase == be_wait_ex) begin
                if (be_cnt == 1) begin
                    case (be_kind)
                        kind_csr: csr_ex = 1'b1;
                        kind_tlb: tlb_ex = 1'b1;
                        default:  ibar_ex = 1'b1;
                    endcase
                    be_phase = be_wait_done;
                    be_cnt = 1 + rand_below(5);
                end else begin
                    be_cnt--;
                end
            end else if (be_phase == be_wait_done) begin
                if (be_kind == kind_ibar) begin
                    if (cache_idle) begin
                        be_phase = be_released;
                    end
                end else begin
                    // a done of the other class must not release the wait
                    if (be_kind == kind_csr) begin
                        tlb_done = (rand_below(2) == 1);
                    end else begin
                        csr_done = (rand_below(2) == 1);
                    end
                    if (be_cnt == 1) begin
                        if (be_kind == kind_csr) begin
                            csr_done = 1'b1;
                        end else begin
                            tlb_done = 1'b1;
                        end
                        be_phase = be_released;
                    end else begin
                        be_cnt--;
                    end
                end
            end
            if (be_phase == be_idle && out_valid && take) begin
                predict(model_pc, exp, k);
                compare_bundle(exp);
                bundles++;
                if (exp.excp_flag[0]) begin
                    fault_seen = 1'b1;
                end
                if (exp.priv != 2'b00) begin
                    be_phase = be_await;
                    be_kind = k;
                    priv_count++;
                end
                model_pc = exp.priv[0] ? exp.pc + 32'd4 : exp.pc_next;
            end
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timed out in %s waiting for %s", test_name, what);
    endtask

    task automatic run_until_fault(input int limit);
        int n;
        n = 0;
        fault_seen = 1'b0;
        while (timeouts == 0 && !fault_seen && n < limit) begin
            step(1'b0, 32'd0);
            n++;
        end
        if (timeouts == 0 && !fault_seen) begin
            note_timeout("a fault bundle");
        end
    endtask

    task automatic run_bundles(input int count, input int limit);
        int n;
        int target;
        n = 0;
        target = bundles + count;
        while (timeouts == 0 && bundles < target && n < limit) begin
            step(1'b0, 32'd0);
            n++;
        end
        if (timeouts == 0 && bundles < target) begin
            note_timeout("bundles");
        end
    endtask

    task automatic wait_for_hold(input int limit);
        int n;
        n = 0;
        while (timeouts == 0 && be_phase != be_wait_ex && be_phase != be_wait_done
               && n < limit) begin
            step(1'b0, 32'd0);
            n++;
        end
        if (timeouts == 0 && be_phase != be_wait_ex && be_phase != be_wait_done) begin
            note_timeout("a serializer wait");
        end
    endtask

    task automatic build_program();
        logic [31:0] w;
        logic [7:0]  top;
        logic [5:0]  widx;
        for (int i = 0; i < mem_words; i++) begin
            widx = i[5:0];
            w = $random(seed);
            if (rand_below(12) == 0) begin
                case (rand_below(3))
                    0:       top = op_ibar;
                    1:       top = op_csr;
                    default: top = op_tlb;
                endcase
            end else begin
                // 0x10 to 0x1f is no serializing class
                top = {4'h1, w[27:24]};
            end
            prog[widx] = {top, w[23:0]};
        end
        // one of each class, in both slots
        prog[6'd5] = {op_ibar, prog[6'd5][23:0]};
        prog[6'd12] = {op_csr, prog[6'd12][23:0]};
        prog[6'd23] = {op_tlb, prog[6'd23][23:0]};
    endtask

    task automatic load_and_reset();
        logic [5:0] widx;
        for (int i = 0; i < mem_words; i++) begin
            @(posedge clk);
            #2;
            widx = i[5:0];
            load_en = 1'b1;
            load_addr = i * 4;
            load_data = prog[widx];
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
        // reset stays high 4 cycles past the last load
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    initial begin
        seed = 70;
        errors = 0;
        timeouts = 0;
        bundles = 0;
        priv_count = 0;
        model_pc = pc_reset;
        fault_seen = 1'b0;
        be_phase = be_idle;
        be_cnt = 0;
        be_kind = kind_none;
        test_name = "reset";
        rst = 1'b1;
        flush = 1'b0;
        flush_pc = 32'd0;
        load_en = 1'b0;
        load_addr = 32'd0;
        load_data = 32'd0;
        out_allowin = 1'b0;
        ibar_ex = 1'b0;
        csr_ex = 1'b0;
        tlb_ex = 1'b0;
        cache_idle = 1'b0;
        csr_done = 1'b0;
        tlb_done = 1'b0;

        build_program();
        load_and_reset();

        test_name = "sequential";
        run_until_fault(3000);

        test_name = "flush_normal";
        step(1'b1, 32'd0);
        run_bundles(8, 400);
        fpc = rand_below(48) * 4;
        step(1'b1, fpc);
        run_until_fault(3000);

        // flush while the serializer is waiting on the back end
        test_name = "flush_wait";
        for (int r = 0; r < 3; r++) begin
            step(1'b1, 32'd0);
            wait_for_hold(1000);
            fpc = rand_below(48) * 4;
            step(1'b1, fpc);
            run_bundles(4, 400);
        end
        run_until_fault(3000);

        $display("errors: %0d  timeouts: %0d  bundles: %0d  serializing: %0d",
                 errors, timeouts, bundles, priv_count);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* bench/fetch_props.sv */
module fetch_props
    import fetch_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input logic          flush,
    input ser_state_t    state_q,
    input logic          rvalid,
    input logic          out_valid,
    input logic          out_allowin,
    input fetch_bundle_t out_bundle
);

    timeunit 1ns;
    timeprecision 100ps;

    logic seen_rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_rvalid <= 1'b0;
        end else if (rvalid) begin
            seen_rvalid <= 1'b1;
        end
    end

    // nothing offered while the serializer waits
    valid_only_idle: assert property (@(posedge clk) disable iff (rst)
        state_q != ser_idle |-> !out_valid)
        else $error("out_valid high while the serializer waits");

    no_valid_before_rvalid: assert property (@(posedge clk) disable iff (rst)
        !seen_rvalid |-> !out_valid)
        else $error("out_valid high before any memory answer");

    // a held bundle keeps its contents
    bundle_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_allowin && !flush |=> out_valid && $stable(out_bundle))
        else $error("bundle changed or dropped under back-pressure");

endmodule

bind if1_fifo fetch_props fetch_props_i (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .state_q     (state_q),
    .rvalid      (rvalid),
    .out_valid   (out_valid),
    .out_allowin (out_allowin),
    .out_bundle  (out_bundle)
);

/* hdl/fetch_top.sv */
module fetch_top
    import fetch_pkg::*;
#(
    parameter int mem_depth = 256
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic [31:0]   flush_pc,
    input  logic          load_en,
    input  logic [31:0]   load_addr,
    input  logic [31:0]   load_data,
    input  logic          out_allowin,
    output logic          out_valid,
    output fetch_bundle_t out_bundle,
    output logic          hold,
    input  logic          ibar_ex,
    input  logic          csr_ex,
    input  logic          tlb_ex,
    input  logic          cache_idle,
    input  logic          csr_done,
    input  logic          tlb_done
);

    logic        fetch_req;
    logic [31:0] fetch_pc;
    logic        fetch_allowin;
    logic        redirect;
    logic [31:0] redirect_pc;

    // memory answer
    logic        rvalid;
    logic [31:0] rpc;
    logic [31:0] mem_inst0;
    logic [31:0] mem_inst1;
    logic [31:0] mem_badv;
    logic [6:0]  mem_exception;
    logic [1:0]  mem_excp_flag;

    // predecode results
    logic [1:0]  pd_priv;
    priv_kind_t  pd_kind;

    fetch_pc_gen pc_gen_i (
        .clk         (clk),
        .rst         (rst),
        .allowin     (fetch_allowin),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc)
    );

    inst_mem #(
        .mem_depth (mem_depth)
    ) inst_mem_i (
        .clk       (clk),
        .rst       (rst),
        .req       (fetch_req),
        .pc        (fetch_pc),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .flush     (flush),
        .rvalid    (rvalid),
        .rpc       (rpc),
        .inst0     (mem_inst0),
        .inst1     (mem_inst1),
        .badv      (mem_badv),
        .exception (mem_exception),
        .excp_flag (mem_excp_flag)
    );

    predecode predecode_i (
        .pc    (rpc),
        .inst0 (mem_inst0),
        .inst1 (mem_inst1),
        .priv  (pd_priv),
        .kind  (pd_kind)
    );

    if1_fifo if1_fifo_i (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .rvalid        (rvalid),
        .rpc           (rpc),
        .inst0         (mem_inst0),
        .inst1         (mem_inst1),
        .badv          (mem_badv),
        .exception     (mem_exception),
        .excp_flag     (mem_excp_flag),
        .priv          (pd_priv),
        .kind          (pd_kind),
        .out_allowin   (out_allowin),
        .out_valid     (out_valid),
        .out_bundle    (out_bundle),
        .fetch_allowin (fetch_allowin),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .hold          (hold),
        .ibar_ex       (ibar_ex),
        .csr_ex        (csr_ex),
        .tlb_ex        (tlb_ex),
        .cache_idle    (cache_idle),
        .csr_done      (csr_done),
        .tlb_done      (tlb_done)
    );

endmodule

/* hdl/if1_fifo.sv */
module if1_fifo
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          rvalid,
    input  logic [31:0]   rpc,
    input  logic [31:0]   inst0,
    input  logic [31:0]   inst1,
    input  logic [31:0]   badv,
    input  logic [6:0]    exception,
    input  logic [1:0]    excp_flag,
    input  logic [1:0]    priv,
    input  priv_kind_t    kind,
    input  logic          out_allowin,
    output logic          out_valid,
    output fetch_bundle_t out_bundle,
    output logic          fetch_allowin,
    output logic          redirect,
    output logic [31:0]   redirect_pc,
    output logic          hold,
    input  logic          ibar_ex,
    input  logic          csr_ex,
    input  logic          tlb_ex,
    input  logic          cache_idle,
    input  logic          csr_done,
    input  logic          tlb_done
);

    // bundle plus the class the serializer needs at transfer
    typedef struct packed {
        fetch_bundle_t bundle;
        priv_kind_t    kind;
    } stage_entry_t;

    ser_state_t   state_q;
    ser_state_t   state_d;
    logic         stage_valid_q;
    logic         skid_valid_q;
    stage_entry_t stage_q;
    stage_entry_t skid_q;
    stage_entry_t new_entry;
    logic         idle;
    logic         xfer;
    logic         ser_start;
    logic         release_ok;
    logic         stage_load;
    logic         skid_load;
    logic [31:0]  after_priv_pc;

    // incoming pair with the slot-disable rules applied
    always_comb begin
        new_entry.bundle.pc        = rpc;
        new_entry.bundle.pc_next   = {rpc[31:3], 3'b000} + 32'd8;
        new_entry.bundle.inst0     = rpc[2] ? inst_nop : inst0;
        new_entry.bundle.inst1     = priv[0] ? inst_nop : inst1;
        new_entry.bundle.badv      = badv;
        new_entry.bundle.exception = exception;
        new_entry.bundle.excp_flag = excp_flag;
        new_entry.bundle.priv      = priv;
        new_entry.kind             = kind;
    end

    assign idle       = (state_q == ser_idle);
    assign hold       = !idle;
    assign out_valid  = stage_valid_q;
    assign out_bundle = stage_q.bundle;
    assign xfer       = out_valid && out_allowin;
    assign ser_start  = xfer && (stage_q.bundle.priv != 2'b00);

    // stage frees up this cycle, or the pair has to park in the skid slot
    assign stage_load = !stage_valid_q || xfer;
    assign skid_load  = rvalid && (skid_valid_q || !stage_load);

    // one more pair only if it cannot find both buffers full
    assign fetch_allowin = idle && !skid_valid_q && !(stage_valid_q && rvalid && !xfer);

    // resume point after the serializing slot
    assign after_priv_pc = stage_q.bundle.priv[0] ? stage_q.bundle.pc + 32'd4
                                                  : {stage_q.bundle.pc[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk) begin
        if (rst || flush || !idle || ser_start) begin
            // anything fetched behind a serializing bundle is dropped
            stage_valid_q <= 1'b0;
            skid_valid_q  <= 1'b0;
        end else begin
            if (stage_load) begin
                stage_valid_q <= skid_valid_q || rvalid;
            end
            skid_valid_q <= skid_load || (skid_valid_q && !stage_load);
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load) begin
            stage_q <= skid_valid_q ? skid_q : new_entry;
        end
        if (skid_load) begin
            skid_q <= new_entry;
        end
    end

    // serializer
    always_comb begin
        state_d    = state_q;
        release_ok = 1'b0;
        case (state_q)
            ser_idle: begin
                if (ser_start) begin
                    case (stage_q.kind)
                        kind_csr: state_d = ser_wait_ex_csr;
                        kind_tlb: state_d = ser_wait_ex_tlb;
                        default:  state_d = ser_wait_ex_ibar;
                    endcase
                end
            end
            ser_wait_ex_ibar: begin
                if (ibar_ex) begin
                    state_d = ser_wait_cache_idle;
                end
            end
            ser_wait_ex_csr: begin
                if (csr_ex) begin
                    state_d = ser_wait_csr_ok;
                end
            end
            ser_wait_ex_tlb: begin
                if (tlb_ex) begin
                    state_d = ser_wait_tlb_ok;
                end
            end
            ser_wait_cache_idle: begin
                release_ok = cache_idle;
            end
            ser_wait_csr_ok: begin
                release_ok = csr_done;
            end
            ser_wait_tlb_ok: begin
                release_ok = tlb_done;
            end
            default: begin
                state_d = ser_idle;
            end
        endcase
        if (release_ok) begin
            state_d = ser_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state_q  <= ser_idle;
            redirect <= 1'b0;
        end else begin
            state_q  <= state_d;
            // first idle cycle steers the pc generator
            redirect <= release_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (ser_start) begin
            redirect_pc <= after_priv_pc;
        end
    end

endmodule

/* hdl/predecode.sv */
module predecode
    import fetch_pkg::*;
(
    input  logic [31:0] pc,
    input  logic [31:0] inst0,
    input  logic [31:0] inst1,
    output logic [1:0]  priv,
    output priv_kind_t  kind
);

    priv_kind_t class0;
    priv_kind_t class1;

    function automatic priv_kind_t classify(input logic [31:0] inst);
        priv_kind_t c;
        case (inst[31:24])
            op_ibar: c = kind_ibar;
            op_csr:  c = kind_csr;
            op_tlb:  c = kind_tlb;
            default: c = kind_none;
        endcase
        return c;
    endfunction

    assign class0 = classify(inst0);
    assign class1 = classify(inst1);

    always_comb begin
        // slot 0 is not delivered for an odd-word pc
        priv[0] = (class0 != kind_none) && !pc[2];
        // slot 1 is dropped behind a serializing slot 0
        priv[1] = (class1 != kind_none) && !priv[0];
    end

    always_comb begin
        if (priv[0]) begin
            kind = class0;
        end else if (priv[1]) begin
            kind = class1;
        end else begin
            kind = kind_none;
        end
    end

endmodule

/* hdl/inst_mem.sv */
module inst_mem
    import fetch_pkg::*;
#(
    parameter int mem_depth = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [31:0] pc,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic        flush,
    output logic        rvalid,
    output logic [31:0] rpc,
    output logic [31:0] inst0,
    output logic [31:0] inst1,
    output logic [31:0] badv,
    output logic [6:0]  exception,
    output logic [1:0]  excp_flag
);

    localparam int addr_w = $clog2(mem_depth);

    logic [31:0]       mem [mem_depth];
    logic [addr_w-1:0] word0_idx;
    logic [addr_w-1:0] word1_idx;
    logic              fault;

    // pair indices, slot 0 always even
    assign word0_idx = {pc[addr_w+1:3], 1'b0};
    assign word1_idx = {pc[addr_w+1:3], 1'b1};

    // anything past 4*mem_depth bytes
    assign fault = (pc >> (addr_w + 2)) != 32'd0;

    // program load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[addr_w+1:2]] <= load_data;
        end
    end

    // answer valid, dropped by flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= req;
        end
    end

    always_ff @(posedge clk) begin
        rpc       <= pc;
        inst0     <= fault ? inst_nop : mem[word0_idx];
        inst1     <= fault ? inst_nop : mem[word1_idx];
        badv      <= fault ? pc : 32'd0;
        exception <= fault ? excp_adef : 7'd0;
        excp_flag <= {1'b0, fault};
    end

endmodule

/* hdl/fetch_pc_gen.sv */
module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        allowin,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    output logic        fetch_req,
    output logic [31:0] fetch_pc
);

    logic        running_q;
    logic [31:0] pc_q;
    logic [31:0] pc_step;

    // set one edge after reset so the first request follows reset
    always_ff @(posedge clk) begin
        if (rst) begin
            running_q <= 1'b0;
        end else begin
            running_q <= 1'b1;
        end
    end

    // no request on a cycle that moves the pc elsewhere
    assign fetch_req = allowin && running_q && !redirect && !flush;
    assign fetch_pc  = pc_q;

    // next aligned pair
    assign pc_step = {pc_q[31:3], 3'b000} + 32'd8;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= pc_reset;
        end else if (flush) begin
            pc_q <= flush_pc;
        end else if (redirect) begin
            // resume after the serializing instruction
            pc_q <= redirect_pc;
        end else if (fetch_req) begin
            pc_q <= pc_step;
        end
    end

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // first fetch address after reset
    localparam logic [31:0] pc_reset = 32'h0000_0000;

    // andi r0, r0, 0 fills a slot that is not delivered
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // opcode classes, bits 31:24 of an instruction
    localparam logic [7:0] op_ibar = 8'h38;
    localparam logic [7:0] op_csr  = 8'h04;
    localparam logic [7:0] op_tlb  = 8'h06;

    // fetch address fault
    localparam logic [6:0] excp_adef = 7'h08;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] badv;
        logic [6:0]  exception;
        // bit 0 set when the pair faulted
        logic [1:0]  excp_flag;
        // per-slot serializing flags
        logic [1:0]  priv;
    } fetch_bundle_t;

    // class of the serializing instruction being waited on
    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_ibar = 2'd1,
        kind_csr  = 2'd2,
        kind_tlb  = 2'd3
    } priv_kind_t;

    typedef enum logic [2:0] {
        ser_idle            = 3'd0,
        ser_wait_ex_ibar    = 3'd1,
        ser_wait_ex_csr     = 3'd2,
        ser_wait_ex_tlb     = 3'd3,
        ser_wait_cache_idle = 3'd4,
        ser_wait_csr_ok     = 3'd5,
        ser_wait_tlb_ok     = 3'd6
    } ser_state_t;

endpackage
